// File: common/bus_defines.svh
// Serial bus widths and memory depth, included by the package and by RTL that sizes vectors
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// Field widths of one serial transfer
// Both lines are sampled in parallel starting one edge after acceptance
// The address field is the longer one and sets the transfer length

// Address bits per transfer, least significant bit first
`define BUS_ADDR_WIDTH 12

// Data bits per transfer, least significant bit first
`define BUS_DATA_WIDTH 8

// Storage of the slave

// One word per address, the full address space is populated
`define BUS_MEM_DEPTH 4096

`endif

// File: common/bus_pkg.sv
// Shared types of the serial bus slave, taken by wildcard import in modules and testbench
`include "bus_defines.svh"

package bus_pkg;

	// Address and data words as they appear after deserialization
	typedef logic [`BUS_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`BUS_DATA_WIDTH-1:0] data_t;

	// Bit position counter, wide enough for the longer serial field
	typedef logic [3:0] bit_count_t;

	// Input port sequence
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0, // Waiting for master_valid with ready high
		RX_SHIFT = 2'd1, // Sampling address and data lines
		RX_DONE  = 2'd2, // All bits in, command strobe to memory
		RX_HOLD  = 2'd3  // Memory cycle, ready still low
	} rx_state_t;

	// Output port sequence
	typedef enum logic {
		TX_IDLE  = 1'b0,
		TX_SHIFT = 1'b1  // slave_valid high, one bit per cycle
	} tx_state_t;

endpackage

// File: slave_port/slave_in_port.sv
// Decode stage of the serial bus slave, accepts a transfer and shifts in address and data
`timescale 1ns/1ps
`include "bus_defines.svh"

module slave_in_port
	import bus_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  master_valid,
	input  logic  read_en,
	input  logic  write_en,
	input  logic  rx_address,
	input  logic  rx_data,
	input  logic  tx_busy,
	output logic  slave_ready,
	output logic  rx_done,
	output logic  wr_cmd,
	output logic  rd_cmd,
	output addr_t address,
	output data_t data
);

	rx_state_t  state;
	rx_state_t  next_state;
	bit_count_t bit_count;
	logic       accept;
	logic       last_bit;
	logic       data_phase;
	logic       wr_latched;
	logic       rd_latched;

	// Ready only when idle and the result stage is not still sending
	assign slave_ready = (state == RX_IDLE) && !tx_busy;
	assign accept      = master_valid && slave_ready;

	// Address field is the longest, it ends the shift phase
	assign last_bit   = (bit_count == bit_count_t'(`BUS_ADDR_WIDTH - 1));
	assign data_phase = (bit_count < bit_count_t'(`BUS_DATA_WIDTH));

	always_comb
	begin
		next_state = state;
		case (state)
			RX_IDLE:
			begin
				if (accept)
					next_state = RX_SHIFT;
			end
			RX_SHIFT:
			begin
				if (last_bit)
					next_state = RX_DONE; // Last address bit taken on this edge
			end
			RX_DONE:
				next_state = RX_HOLD;
			RX_HOLD:
				next_state = RX_IDLE; // Memory has acted by now
			default:
				next_state = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= RX_IDLE;
		else
			state <= next_state;
	end

	// Counts sampled bits, cleared whenever not shifting
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			bit_count <= '0;
		else if (state == RX_SHIFT)
			bit_count <= bit_count + 1'b1;
		else
			bit_count <= '0;
	end

	// Command is captured on the accepting edge, write has priority
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_latched <= 1'b0;
			rd_latched <= 1'b0;
		end
		else if (accept)
		begin
			wr_latched <= write_en;
			rd_latched <= read_en && !write_en;
		end
	end

	// Both lines shift in from the top so the first bit ends up at bit 0
	always_ff @(posedge clk)
	begin
		if (state == RX_SHIFT)
		begin
			address <= {rx_address, address[`BUS_ADDR_WIDTH-1:1]};
			if (data_phase)
				data <= {rx_data, data[`BUS_DATA_WIDTH-1:1]};
		end
	end

	// One cycle strobes to the execute stage
	assign rx_done = (state == RX_DONE);
	assign wr_cmd  = rx_done && wr_latched;
	assign rd_cmd  = rx_done && rd_latched; // Neither set means bits are dropped

endmodule

// File: slave_port/slave_out_port.sv
// Result stage of the serial bus slave, shifts a read word out on tx_data under slave_valid
`timescale 1ns/1ps
`include "bus_defines.svh"

module slave_out_port
	import bus_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  rd_valid,
	input  data_t rd_word,
	output logic  slave_valid,
	output logic  tx_data,
	output logic  tx_busy
);

	tx_state_t  state;
	tx_state_t  next_state;
	bit_count_t bit_count;
	logic       last_bit;
	data_t      shift_reg;

	assign last_bit = (bit_count == bit_count_t'(`BUS_DATA_WIDTH - 1));

	always_comb
	begin
		next_state = state;
		case (state)
			TX_IDLE:
			begin
				if (rd_valid)
					next_state = TX_SHIFT; // Word arrives from memory
			end
			TX_SHIFT:
			begin
				if (last_bit)
					next_state = TX_IDLE;
			end
			default:
				next_state = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= TX_IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			bit_count <= '0;
		else if (state == TX_SHIFT)
			bit_count <= bit_count + 1'b1;
		else
			bit_count <= '0;
	end

	// Load on the memory pulse, then move one bit down per cycle
	always_ff @(posedge clk)
	begin
		if (state == TX_IDLE && rd_valid)
			shift_reg <= rd_word;
		else if (state == TX_SHIFT)
			shift_reg <= {1'b0, shift_reg[`BUS_DATA_WIDTH-1:1]};
	end

	assign slave_valid = (state == TX_SHIFT);
	assign tx_data     = slave_valid && shift_reg[0]; // Low outside the valid window
	assign tx_busy     = slave_valid; // Keeps the decode stage from accepting

endmodule

// File: hdl/slave_memory.sv
// Execute stage of the serial bus slave, stores written words and returns read words
`timescale 1ns/1ps
`include "bus_defines.svh"

module slave_memory
	import bus_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  wr_cmd,
	input  logic  rd_cmd,
	input  addr_t address,
	input  data_t data,
	output data_t rd_word,
	output logic  rd_valid
);

	// Storage array, contents undefined until written
	data_t mem [0:`BUS_MEM_DEPTH-1];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wr_cmd)
			mem[address] <= data;
	end

	// Read data register, one cycle after the command strobe
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rd_word <= '0;
		else if (rd_cmd)
			rd_word <= mem[address];
	end

	// Pulse that tells the result stage to load rd_word
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_cmd;
	end

endmodule

// File: hdl/bus_slave.sv
// Top level of the serial bus slave, connects decode, execute and result stages to the bus pins
`timescale 1ns/1ps

module bus_slave
	import bus_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic master_valid,
	input  logic read_en,
	input  logic write_en,
	input  logic rx_address,
	input  logic rx_data,
	output logic slave_ready,
	output logic rx_done,
	output logic slave_valid,
	output logic tx_data
);

	addr_t address;   // Deserialized address to memory
	data_t data;      // Deserialized write data to memory
	logic  wr_cmd;
	logic  rd_cmd;
	data_t rd_word;
	logic  rd_valid;
	logic  tx_busy;   // Result stage still sending

	slave_in_port u_in_port (
		.clk          (clk),
		.reset        (reset),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.tx_busy      (tx_busy),
		.slave_ready  (slave_ready),
		.rx_done      (rx_done),
		.wr_cmd       (wr_cmd),
		.rd_cmd       (rd_cmd),
		.address      (address),
		.data         (data)
	);

	slave_memory u_memory (
		.clk      (clk),
		.reset    (reset),
		.wr_cmd   (wr_cmd),
		.rd_cmd   (rd_cmd),
		.address  (address),
		.data     (data),
		.rd_word  (rd_word),
		.rd_valid (rd_valid)
	);

	slave_out_port u_out_port (
		.clk         (clk),
		.reset       (reset),
		.rd_valid    (rd_valid),
		.rd_word     (rd_word),
		.slave_valid (slave_valid),
		.tx_data     (tx_data),
		.tx_busy     (tx_busy)
	);

endmodule

// File: tests/bus_slave_tb.sv
// Self-checking testbench for the serial bus slave, compiled with the RTL and run as top module
`timescale 1ns/1ps
`include "bus_defines.svh"

module bus_slave_tb
	import bus_pkg::*;
();

	// Interval n is the clock period after edge En, E0 being the accepting edge
	localparam int TIMEOUT_CYCLES  = 3000;
	localparam int DONE_REL        = `BUS_ADDR_WIDTH;      // Period after the last address bit
	localparam int WRITE_READY_REL = `BUS_ADDR_WIDTH + 2;  // Decode stage idle again
	localparam int FIRST_BIT_REL   = `BUS_ADDR_WIDTH + 2;  // Result stage loaded after memory cycle
	localparam int READ_READY_REL  = `BUS_ADDR_WIDTH + 2 + `BUS_DATA_WIDTH;

	logic clk;
	logic reset;
	logic master_valid;
	logic read_en;
	logic write_en;
	logic rx_address;
	logic rx_data;
	logic slave_ready;
	logic rx_done;
	logic slave_valid;
	logic tx_data;

	int          cycle = 0;
	int          value_errors = 0;
	int          protocol_errors = 0;
	logic [31:0] lcg_state = 32'h4608_219a;
	data_t       ref_mem [0:`BUS_MEM_DEPTH-1];  // Expected memory contents

	// Monitor results for the most recent accepted transfer
	int    rel = 0;
	int    done_count = 0;
	int    done_rel = -1;
	int    valid_count = 0;
	int    valid_first = -1;
	int    ready_back = -1;
	data_t rx_word = '0;

	bus_slave dut0 (
		.clk          (clk),
		.reset        (reset),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.slave_ready  (slave_ready),
		.rx_done      (rx_done),
		.slave_valid  (slave_valid),
		.tx_data      (tx_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// Ready is never high while a transfer completes or a word goes out
	assert property (@(negedge clk) disable iff (reset) rx_done |-> !slave_ready)
		else
		begin
			protocol_errors++;
			$display("rx_done was high while slave_ready was high, cycle %0d", cycle);
		end
	assert property (@(negedge clk) disable iff (reset) slave_valid |-> !slave_ready)
		else
		begin
			protocol_errors++;
			$display("slave_valid was high while slave_ready was high, cycle %0d", cycle);
		end

	// Samples in the middle of each period and records events relative to acceptance
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (master_valid && slave_ready)
			begin
				rel = -1;  // Next rising edge is E0
				done_count = 0;
				done_rel = -1;
				valid_count = 0;
				valid_first = -1;
				ready_back = -1;
				rx_word = '0;
			end
			else
			begin
				rel = rel + 1;
				if (rx_done)
				begin
					done_count++;
					done_rel = rel;
				end
				if (slave_valid)
				begin
					if (valid_count == 0)
						valid_first = rel;
					if (valid_count < `BUS_DATA_WIDTH)
						rx_word[valid_count] = tx_data;  // LSB first
					valid_count++;
				end
				if (slave_ready && ready_back < 0)
					ready_back = rel;
			end
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		value_errors++;
		$display("ERR %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
	endtask

	// Raises master_valid when ready, then serializes both fields from E0 to E11
	task automatic send_transfer(input logic wr, input logic rd, input addr_t addr,
		input data_t wdata);
		@(negedge clk);
		while (!slave_ready)
			@(negedge clk);
		@(posedge clk);
		master_valid <= 1'b1;
		write_en     <= wr;
		read_en      <= rd;
		@(posedge clk);
		master_valid <= 1'b0;
		write_en     <= 1'b0;  // Command must already be latched
		read_en      <= 1'b0;
		for (int i = 0; i < `BUS_ADDR_WIDTH; i++)
		begin
			rx_address <= addr[i];
			rx_data    <= (i < `BUS_DATA_WIDTH) ? wdata[i] : 1'b0;
			@(posedge clk);
		end
		rx_address <= 1'b0;
		rx_data    <= 1'b0;
	endtask

	task automatic wait_ready_back();
		while (ready_back < 0)
			@(posedge clk);
	endtask

	// One cycle master_valid with a write command while the slave is busy
	task automatic inject_busy_pulse(input int delay);
		repeat (delay)
			@(posedge clk);
		master_valid <= 1'b1;
		write_en     <= 1'b1;
		rx_address   <= 1'b1;
		rx_data      <= 1'b1;
		@(posedge clk);
		master_valid <= 1'b0;
		write_en     <= 1'b0;
		rx_address   <= 1'b0;
		rx_data      <= 1'b0;
	endtask

	task automatic check_timing(input string name, input logic is_read);
		int exp_ready;
		int exp_valid;
		exp_ready = is_read ? READ_READY_REL : WRITE_READY_REL;
		exp_valid = is_read ? `BUS_DATA_WIDTH : 0;
		assert (done_count == 1)
			else report_mismatch({name, " rx_done length"}, 1, done_count);
		assert (done_rel == DONE_REL)
			else report_mismatch({name, " rx_done cycle"}, DONE_REL, done_rel);
		assert (ready_back == exp_ready)
			else report_mismatch({name, " ready return"}, exp_ready, ready_back);
		assert (valid_count == exp_valid)
			else report_mismatch({name, " slave_valid length"}, exp_valid, valid_count);
		if (is_read)
		begin
			assert (valid_first == FIRST_BIT_REL)
				else report_mismatch({name, " first bit cycle"}, FIRST_BIT_REL, valid_first);
		end
	endtask

	task automatic write_word(input string name, input addr_t addr, input data_t wdata);
		send_transfer(1'b1, 1'b0, addr, wdata);
		wait_ready_back();
		check_timing(name, 1'b0);
		ref_mem[addr] = wdata;
	endtask

	task automatic read_word(input string name, input addr_t addr);
		send_transfer(1'b0, 1'b1, addr, '0);
		wait_ready_back();
		check_timing(name, 1'b1);
		assert (rx_word === ref_mem[addr])
			else report_mismatch({name, " data"}, ref_mem[addr], rx_word);
	endtask

	initial
	begin
		addr_t rand_addr [0:24];
		data_t rand_data;
		reset        = 1'b1;
		master_valid = 1'b0;
		read_en      = 1'b0;
		write_en     = 1'b0;
		rx_address   = 1'b0;
		rx_data      = 1'b0;
		repeat (5)
			@(posedge clk);
		reset <= 1'b0;

		// Idle bus after reset
		repeat (10)
		begin
			@(negedge clk);
			assert (slave_ready === 1'b1) else report_mismatch("idle ready", 1, slave_ready);
			assert (rx_done === 1'b0) else report_mismatch("idle rx_done", 0, rx_done);
			assert (slave_valid === 1'b0) else report_mismatch("idle valid", 0, slave_valid);
			assert (tx_data === 1'b0) else report_mismatch("idle tx_data", 0, tx_data);
		end

		// Write then read, MSB and LSB of data differ
		write_word("write 0a5", 12'h0a5, 8'hb4);
		read_word("read 0a5", 12'h0a5);
		write_word("write 000", 12'h000, 8'hc3);
		read_word("read 000", 12'h000);

		// Busy windows with a rejected write pulse
		send_transfer(1'b1, 1'b0, 12'h3c1, 8'h5e);
		inject_busy_pulse(1);
		wait_ready_back();
		check_timing("busy write", 1'b0);
		ref_mem[12'h3c1] = 8'h5e;
		send_transfer(1'b0, 1'b1, 12'h3c1, '0);
		inject_busy_pulse(8);
		wait_ready_back();
		check_timing("busy read", 1'b1);
		assert (rx_word === ref_mem[12'h3c1])
			else report_mismatch("busy read data", ref_mem[12'h3c1], rx_word);
		read_word("after busy 3c1", 12'h3c1);
		read_word("after busy 000", 12'h000);

		// Both enables act as a write
		send_transfer(1'b1, 1'b1, 12'hfff, 8'h81);
		wait_ready_back();
		check_timing("both enables", 1'b0);
		ref_mem[12'hfff] = 8'h81;
		read_word("read fff", 12'hfff);

		// No enable, bits received but memory untouched
		send_transfer(1'b0, 1'b0, 12'h0a5, 8'h00);
		wait_ready_back();
		check_timing("no enable", 1'b0);
		read_word("after no enable", 12'h0a5);

		// Random writes, every fifth one reuses an earlier address
		for (int n = 0; n < 25; n++)
		begin
			lcg_state = lcg_next(lcg_state);
			if (n % 5 == 4)
				rand_addr[n] = rand_addr[n-2];
			else
				rand_addr[n] = lcg_state[27:16];
			lcg_state = lcg_next(lcg_state);
			rand_data = lcg_state[23:16];
			write_word("random write", rand_addr[n], rand_data);
		end
		for (int n = 0; n < 25; n++)
			read_word("random read", rand_addr[n]);

		repeat (3)
			@(posedge clk);
		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: serial_bus_slave.f
+incdir+common
common/bus_pkg.sv
slave_port/slave_in_port.sv
slave_port/slave_out_port.sv
hdl/slave_memory.sv
hdl/bus_slave.sv
tests/bus_slave_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the serial bus slave testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module bus_slave_tb -f serial_bus_slave.f \
	--Mdir obj_dir -o bus_slave_sim > build.log 2>&1 \
	&& ./obj_dir/bus_slave_sim > sim.log 2>&1 \
	|| echo "Build or simulation did not complete, see build.log and sim.log"

grep -q "TESTS PASSED" sim.log 2>/dev/null \
	&& echo "Simulation result: pass" \
	&& exit 0 \
	|| { echo "Simulation result: fail"; exit 1; }
